/* design/dmem_pkg.sv */
// Shared types for the memory subsystem: access widths, FSM states and Wishbone buses
`include "dmem_consts.svh"

package dmem_pkg;

  // Access width and signedness, same encoding as the core's MemOP field
  typedef enum logic [2:0] {
    MEM_B    = 3'b000,
    MEM_BU   = 3'b001,
    MEM_H    = 3'b010,
    MEM_HU   = 3'b011,
    MEM_W    = 3'b100,
    MEM_WU   = 3'b101,
    MEM_D    = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_BUS,    // Wishbone cycle open
    LSU_FAULT   // No bus cycle, done on the next edge
  } lsu_state_e;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_BUS
  } fetch_state_e;

  // Master to slave
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`DMEM_XLEN-1:0]  adr;  // Byte address
    logic [`DMEM_XLEN-1:0]  dat;
    logic [`DMEM_SEL_W-1:0] sel;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                  ack;
    logic [`DMEM_XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

/* design/fetch_port.sv */
// CPU fetch port: issues full-word Wishbone reads and returns the addressed instruction
`timescale 1ns/10ps
`include "dmem_consts.svh"

module fetch_port (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_fetch_req,
  input  logic [`DMEM_XLEN-1:0] i_pc,
  output logic                  o_fetch_busy,
  output logic                  o_fetch_done,
  output logic                  o_fetch_fault,
  output logic [`DMEM_ILEN-1:0] o_instr,
  output dmem_pkg::wb_req_t     o_wb,
  input  dmem_pkg::wb_rsp_t     i_wb
);

  dmem_pkg::fetch_state_e state;
  logic                   accept;
  logic                   misaligned;
  logic                   r_flt_pend;  // Misaligned pc, done on the next edge
  logic                   r_hi;        // Upper half of the word
  logic [`DMEM_XLEN-1:0]  r_adr;

  assign o_fetch_busy = (state == dmem_pkg::FETCH_BUS) | r_flt_pend;
  assign accept       = i_fetch_req & ~o_fetch_busy;
  assign misaligned   = (i_pc[1:0] != 2'b00);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= dmem_pkg::FETCH_IDLE;
      r_flt_pend    <= 1'b0;
      o_fetch_done  <= 1'b0;
      o_fetch_fault <= 1'b0;
    end else begin
      o_fetch_done <= r_flt_pend;
      r_flt_pend   <= 1'b0;
      case (state)
        dmem_pkg::FETCH_IDLE: begin
          if (accept) begin
            o_fetch_fault <= misaligned;
            if (misaligned) r_flt_pend <= 1'b1;
            else            state      <= dmem_pkg::FETCH_BUS;
          end
        end
        dmem_pkg::FETCH_BUS: begin
          if (i_wb.ack) begin
            state        <= dmem_pkg::FETCH_IDLE;
            o_fetch_done <= 1'b1;
          end
        end
        default: state <= dmem_pkg::FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      r_adr <= {i_pc[`DMEM_XLEN-1:`DMEM_OFF_W], {`DMEM_OFF_W{1'b0}}};  // Word aligned
      r_hi  <= i_pc[2];
    end
    if (state == dmem_pkg::FETCH_BUS && i_wb.ack)
      o_instr <= r_hi ? i_wb.dat[`DMEM_XLEN-1:`DMEM_ILEN] : i_wb.dat[`DMEM_ILEN-1:0];
    else if (r_flt_pend)
      o_instr <= '0;
  end

  // Read only, all lanes
  always_comb begin
    o_wb.cyc = (state == dmem_pkg::FETCH_BUS);
    o_wb.stb = (state == dmem_pkg::FETCH_BUS);
    o_wb.we  = 1'b0;
    o_wb.adr = r_adr;
    o_wb.dat = '0;
    o_wb.sel = '1;
  end

endmodule

/* design/load_store_unit.sv */
// CPU data port: turns load/store requests into masked Wishbone cycles and shapes load data
`timescale 1ns/10ps
`include "dmem_consts.svh"

module load_store_unit (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_req,
  input  dmem_pkg::mem_op_e     i_op,
  input  logic                  i_we,
  input  logic [`DMEM_XLEN-1:0] i_addr,
  input  logic [`DMEM_XLEN-1:0] i_wdata,
  output logic                  o_busy,
  output logic                  o_done,
  output logic                  o_fault,
  output logic [`DMEM_XLEN-1:0] o_rdata,
  output dmem_pkg::wb_req_t     o_wb,
  input  dmem_pkg::wb_rsp_t     i_wb
);

  dmem_pkg::lsu_state_e   state;
  logic [`DMEM_OFF_W-1:0] off;
  logic [`DMEM_SEL_W-1:0] mask;
  logic [`DMEM_XLEN-1:0]  lane_wdata;
  logic                   accept;
  logic                   misaligned;

  dmem_pkg::mem_op_e      r_op;
  logic                   r_we;
  logic [`DMEM_XLEN-1:0]  r_adr;
  logic [`DMEM_XLEN-1:0]  r_dat;
  logic [`DMEM_SEL_W-1:0] r_sel;

  logic [`DMEM_XLEN-1:0]  shifted;
  logic [`DMEM_XLEN-1:0]  load_data;

  // ***************************************************************************
  // Request decode
  // ***************************************************************************

  assign off    = i_addr[`DMEM_OFF_W-1:0];
  assign o_busy = (state != dmem_pkg::LSU_IDLE);
  assign accept = i_req & ~o_busy;

  // Byte lanes by width, zero when the access crosses its natural boundary
  always_comb begin
    mask = '0;
    case (i_op)
      dmem_pkg::MEM_B, dmem_pkg::MEM_BU: mask = 8'b0000_0001 << off;
      dmem_pkg::MEM_H, dmem_pkg::MEM_HU: if (off[0] == 1'b0) mask = 8'b0000_0011 << off;
      dmem_pkg::MEM_W, dmem_pkg::MEM_WU: if (off[1:0] == 2'b00) mask = 8'b0000_1111 << off;
      dmem_pkg::MEM_D:                   if (off == '0) mask = 8'b1111_1111;
      default:                           mask = '0;
    endcase
  end

  assign misaligned = (i_op != dmem_pkg::MEM_NONE) && (mask == '0);
  assign lane_wdata = i_wdata << {off, 3'b000};  // Store data into its byte lane

  // ***************************************************************************
  // Control
  // ***************************************************************************

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= dmem_pkg::LSU_IDLE;
      o_done  <= 1'b0;
      o_fault <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        dmem_pkg::LSU_IDLE: begin
          if (accept) begin
            o_fault <= misaligned;
            if (misaligned || i_op == dmem_pkg::MEM_NONE)
              state <= dmem_pkg::LSU_FAULT;
            else
              state <= dmem_pkg::LSU_BUS;
          end
        end
        dmem_pkg::LSU_BUS: begin
          if (i_wb.ack) begin
            state  <= dmem_pkg::LSU_IDLE;  // Drops cyc/stb after ack
            o_done <= 1'b1;
          end
        end
        dmem_pkg::LSU_FAULT: begin
          state  <= dmem_pkg::LSU_IDLE;
          o_done <= 1'b1;
        end
        default: state <= dmem_pkg::LSU_IDLE;
      endcase
    end
  end

  // Held steady for the whole bus cycle
  always_ff @(posedge i_clk) begin
    if (accept) begin
      r_op  <= i_op;
      r_we  <= i_we;
      r_adr <= i_addr;
      r_dat <= lane_wdata;
      r_sel <= mask;
    end
  end

  always_comb begin
    o_wb.cyc = (state == dmem_pkg::LSU_BUS);
    o_wb.stb = (state == dmem_pkg::LSU_BUS);
    o_wb.we  = r_we;
    o_wb.adr = r_adr;
    o_wb.dat = r_dat;
    o_wb.sel = r_sel;
  end

  // ***************************************************************************
  // Load data
  // ***************************************************************************

  assign shifted = i_wb.dat >> {r_adr[`DMEM_OFF_W-1:0], 3'b000};

  always_comb begin
    case (r_op)
      dmem_pkg::MEM_B:  load_data = {{(`DMEM_XLEN-8){shifted[7]}}, shifted[7:0]};
      dmem_pkg::MEM_BU: load_data = {{(`DMEM_XLEN-8){1'b0}}, shifted[7:0]};
      dmem_pkg::MEM_H:  load_data = {{(`DMEM_XLEN-16){shifted[15]}}, shifted[15:0]};
      dmem_pkg::MEM_HU: load_data = {{(`DMEM_XLEN-16){1'b0}}, shifted[15:0]};
      dmem_pkg::MEM_W:  load_data = {{(`DMEM_XLEN-32){shifted[31]}}, shifted[31:0]};
      dmem_pkg::MEM_WU: load_data = {{(`DMEM_XLEN-32){1'b0}}, shifted[31:0]};
      default:          load_data = shifted;  // MEM_D
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (state == dmem_pkg::LSU_BUS && i_wb.ack && !r_we)
      o_rdata <= load_data;
    else if (state == dmem_pkg::LSU_FAULT)
      o_rdata <= '0;
  end

  // Every bus cycle carries at least one byte lane
  a_sel_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb.stb |-> (o_wb.sel != '0));

endmodule

/* design/mem_subsystem.sv */
// Memory subsystem top: CPU data and fetch ports sharing one SRAM over Wishbone
`timescale 1ns/10ps
`include "dmem_consts.svh"

module mem_subsystem (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Data port
  input  logic                  i_req,
  input  dmem_pkg::mem_op_e     i_op,
  input  logic                  i_we,
  input  logic [`DMEM_XLEN-1:0] i_addr,
  input  logic [`DMEM_XLEN-1:0] i_wdata,
  output logic                  o_busy,
  output logic                  o_done,
  output logic                  o_fault,
  output logic [`DMEM_XLEN-1:0] o_rdata,
  // Fetch port
  input  logic                  i_fetch_req,
  input  logic [`DMEM_XLEN-1:0] i_pc,
  output logic                  o_fetch_busy,
  output logic                  o_fetch_done,
  output logic                  o_fetch_fault,
  output logic [`DMEM_ILEN-1:0] o_instr
);

  dmem_pkg::wb_req_t lsu_req;
  dmem_pkg::wb_rsp_t lsu_rsp;
  dmem_pkg::wb_req_t fetch_req;
  dmem_pkg::wb_rsp_t fetch_rsp;
  dmem_pkg::wb_req_t sram_req;
  dmem_pkg::wb_rsp_t sram_rsp;

  load_store_unit u_load_store_unit (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .i_op    (i_op),
    .i_we    (i_we),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_busy  (o_busy),
    .o_done  (o_done),
    .o_fault (o_fault),
    .o_rdata (o_rdata),
    .o_wb    (lsu_req),
    .i_wb    (lsu_rsp)
  );

  fetch_port u_fetch_port (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_fetch_req   (i_fetch_req),
    .i_pc          (i_pc),
    .o_fetch_busy  (o_fetch_busy),
    .o_fetch_done  (o_fetch_done),
    .o_fetch_fault (o_fetch_fault),
    .o_instr       (o_instr),
    .o_wb          (fetch_req),
    .i_wb          (fetch_rsp)
  );

  // LSU is master 0
  wb_arbiter u_wb_arbiter (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_m0     (lsu_req),
    .i_m1     (fetch_req),
    .o_m0_rsp (lsu_rsp),
    .o_m1_rsp (fetch_rsp),
    .o_s      (sram_req),
    .i_s_rsp  (sram_rsp)
  );

  wb_sram u_wb_sram (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_wb  (sram_req),
    .o_wb  (sram_rsp)
  );

endmodule

/* design/wb_arbiter.sv */
// Round-robin arbiter that hands one shared Wishbone slave to the LSU or the fetch port
`timescale 1ns/10ps

module wb_arbiter (
  input  logic              i_clk,
  input  logic              i_rst,
  input  dmem_pkg::wb_req_t i_m0,      // LSU
  input  dmem_pkg::wb_req_t i_m1,      // Fetch
  output dmem_pkg::wb_rsp_t o_m0_rsp,
  output dmem_pkg::wb_rsp_t o_m1_rsp,
  output dmem_pkg::wb_req_t o_s,
  input  dmem_pkg::wb_rsp_t i_s_rsp
);

  logic r_owner;    // Master granted last cycle
  logic r_last;     // Master whose cycle was acked last
  logic owner_cyc;
  logic grant;

  // ***************************************************************************
  // Grant
  // ***************************************************************************

  always_comb begin
    owner_cyc = r_owner ? i_m1.cyc : i_m0.cyc;
    if (owner_cyc)
      grant = r_owner;               // Bus locked until the owner drops cyc
    else if (i_m0.cyc && i_m1.cyc)
      grant = ~r_last;
    else if (i_m0.cyc)
      grant = 1'b0;
    else if (i_m1.cyc)
      grant = 1'b1;
    else
      grant = ~r_last;               // Idle bus parks on the master next in turn
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_owner <= 1'b0;
      r_last  <= 1'b1;               // LSU wins the first tie
    end else begin
      r_owner <= grant;
      if (i_s_rsp.ack) r_last <= grant;
    end
  end

  // ***************************************************************************
  // Routing
  // ***************************************************************************

  // The loser's cyc and stb never reach the slave
  always_comb begin
    o_s = grant ? i_m1 : i_m0;

    o_m0_rsp.dat = i_s_rsp.dat;
    o_m0_rsp.ack = i_s_rsp.ack & ~grant;
    o_m1_rsp.dat = i_s_rsp.dat;
    o_m1_rsp.ack = i_s_rsp.ack & grant;
  end

  // A cycle still waiting for ack keeps the same owner on the next edge
  a_grant_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_s.cyc && !i_s_rsp.ack) |=> (grant == $past(grant)));

endmodule

/* design/wb_sram.sv */
// Shared 64-bit SRAM behind a Wishbone classic slave port with byte selects
`timescale 1ns/10ps
`include "dmem_consts.svh"

module wb_sram (
  input  logic              i_clk,
  input  logic              i_rst,
  input  dmem_pkg::wb_req_t i_wb,
  output dmem_pkg::wb_rsp_t o_wb
);

  logic [`DMEM_XLEN-1:0]       mem [2**`DMEM_DEPTH_LOG2];
  logic [`DMEM_DEPTH_LOG2-1:0] idx;
  logic                        req;
  logic                        r_ack;
  logic [`DMEM_XLEN-1:0]       r_dat;

  // Word index from the byte address with the upper bits wrapping
  assign idx = i_wb.adr[`DMEM_DEPTH_LOG2+`DMEM_OFF_W-1:`DMEM_OFF_W];
  assign req = i_wb.cyc & i_wb.stb & ~r_ack;  // New access not yet acked

  always_ff @(posedge i_clk) begin
    if (i_rst)
      r_ack <= 1'b0;
    else
      r_ack <= req;    // Single-cycle pulse
  end

  // ***************************************************************************
  // Array
  // ***************************************************************************

  always_ff @(posedge i_clk) begin
    if (req) begin
      if (i_wb.we) begin
        for (int b = 0; b < `DMEM_SEL_W; b++) begin
          if (i_wb.sel[b]) mem[idx][8*b +: 8] <= i_wb.dat[8*b +: 8];
        end
      end
      r_dat <= mem[idx];
    end
  end

  assign o_wb = '{ack: r_ack, dat: r_dat};

  // Ack answers a strobe seen on the edge before and still held at the same address
  a_ack_follows_stb: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb.ack |-> ($past(i_wb.cyc && i_wb.stb) && i_wb.cyc && i_wb.stb &&
                  $stable(i_wb.adr)));

endmodule

/* include/dmem_consts.svh */
// Bus, word and SRAM size constants shared by the memory RTL and its testbench
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// ***************************************************************************
// Data path
// ***************************************************************************

// One machine word, also the Wishbone data and address width
`define DMEM_XLEN 64

// Byte selects per word
`define DMEM_SEL_W 8

// Address bits that pick a byte inside a word
`define DMEM_OFF_W 3

// Instruction width returned by the fetch port
`define DMEM_ILEN 32

// ***************************************************************************
// SRAM size
// ***************************************************************************

// Word index bits, higher address bits wrap
`define DMEM_DEPTH_LOG2 10

`endif

/* mem_subsystem.f */
+incdir+include
design/dmem_pkg.sv
design/load_store_unit.sv
design/fetch_port.sv
design/wb_arbiter.sv
design/wb_sram.sv
design/mem_subsystem.sv
test/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module mem_subsystem_tb -f mem_subsystem.f -o mem_subsystem_sim \
  && ./obj_dir/mem_subsystem_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log && echo "Simulation passed" && exit 0
echo "Simulation failed" || true
exit 1

/* test/mem_subsystem_tb.sv */
// Self-checking testbench: replays the tests file on the data and fetch ports of the memory top
`timescale 1ns/10ps
`include "dmem_consts.svh"

module mem_subsystem_tb;

  localparam int RESET_CYCLES = 8;
  localparam int DONE_WAIT    = 16;  // Cycles allowed for one request

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_req;
  dmem_pkg::mem_op_e     i_op;
  logic                  i_we;
  logic [`DMEM_XLEN-1:0] i_addr;
  logic [`DMEM_XLEN-1:0] i_wdata;
  logic                  o_busy;
  logic                  o_done;
  logic                  o_fault;
  logic [`DMEM_XLEN-1:0] o_rdata;
  logic                  i_fetch_req;
  logic [`DMEM_XLEN-1:0] i_pc;
  logic                  o_fetch_busy;
  logic                  o_fetch_done;
  logic                  o_fetch_fault;
  logic [`DMEM_ILEN-1:0] o_instr;

  // One entry per line of the tests file
  string                 t_kind [$];
  logic [2:0]            t_op   [$];
  logic [`DMEM_XLEN-1:0] t_addr [$];
  logic [`DMEM_XLEN-1:0] t_data [$];
  logic [`DMEM_XLEN-1:0] t_exp  [$];
  logic                  t_flt  [$];

  int          pass_cnt;
  int          fail_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] lfsr;

  mem_subsystem u_mem_subsystem (.*);

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ***************************************************************************
  // Helpers
  // ***************************************************************************

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic pick_idle(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      n    = (n << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic load_tests(output bit ok);
    int                    fd;
    int                    n;
    string                 line;
    string                 kind;
    logic [2:0]            op;
    logic [`DMEM_XLEN-1:0] addr;
    logic [`DMEM_XLEN-1:0] data;
    logic [`DMEM_XLEN-1:0] exp;
    logic                  flt;
    ok = 1'b1;
    fd = $fopen("test/mem_subsystem_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/mem_subsystem_tests.txt");
      ok = 1'b0;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h", kind, op, addr, data, exp, flt);
      if (n != 6 || !(kind == "store" || kind == "load" || kind == "fetch" || kind == "both")) begin
        $display("Could not read this test line: %s", line);
        ok = 1'b0;
        continue;
      end
      t_kind.push_back(kind);
      t_op.push_back(op);
      t_addr.push_back(addr);
      t_data.push_back(data);
      t_exp.push_back(exp);
      t_flt.push_back(flt);
    end
    $fclose(fd);
  endtask

  task automatic check_reset_state();
    if (o_done || o_fault || o_busy || o_fetch_done || o_fetch_busy) begin
      $display("Fail at time %0t: outputs not idle after reset", $time);
      fail_cnt++;
    end else begin
      $display("Test reset ok");
      pass_cnt++;
    end
  endtask

  // ***************************************************************************
  // One test: drive, wait for the done pulses, compare
  // ***************************************************************************

  task automatic run_test(input int idx);
    string                 kind;
    bit                    want_lsu;
    bit                    want_fetch;
    bit                    ok;
    int                    waited;
    logic                  got_done;
    logic                  got_fault;
    logic [`DMEM_XLEN-1:0] got_rdata;
    logic                  got_fdone;
    logic                  got_ffault;
    logic [`DMEM_ILEN-1:0] got_instr;
    logic [`DMEM_XLEN-1:0] exp_rdata;
    logic [`DMEM_ILEN-1:0] exp_instr;
    logic                  exp_flt;
    kind       = t_kind[idx];
    exp_rdata  = t_exp[idx];
    exp_flt    = t_flt[idx];
    exp_instr  = (kind == "both") ? t_data[idx][`DMEM_ILEN-1:0] : t_exp[idx][`DMEM_ILEN-1:0];
    want_lsu   = (kind != "fetch");
    want_fetch = (kind == "fetch") || (kind == "both");
    ok         = 1'b1;
    got_done   = 1'b0;
    got_fdone  = 1'b0;

    i_req       = want_lsu;
    i_op        = dmem_pkg::mem_op_e'(t_op[idx]);
    i_we        = (kind == "store");
    i_addr      = t_addr[idx];
    i_wdata     = t_data[idx];
    i_fetch_req = want_fetch;
    i_pc        = t_addr[idx];
    waited      = 0;
    while (((want_lsu && !got_done) || (want_fetch && !got_fdone)) && waited < DONE_WAIT) begin
      @(posedge i_clk);
      #1;
      waited++;
      if (o_busy || o_done) i_req = 1'b0;  // Accepted
      if (o_fetch_busy || o_fetch_done) i_fetch_req = 1'b0;
      if (o_done) begin
        got_done  = 1'b1;
        got_fault = o_fault;
        got_rdata = o_rdata;
      end
      if (o_fetch_done) begin
        got_fdone  = 1'b1;
        got_ffault = o_fetch_fault;
        got_instr  = o_instr;
      end
    end
    i_req       = 1'b0;
    i_fetch_req = 1'b0;

    if (want_lsu && !got_done) begin
      $display("Test %0d: the data port gave no done pulse within %0d cycles", idx, DONE_WAIT);
      ok = 1'b0;
    end
    if (want_lsu && got_done && got_fault !== exp_flt) begin
      $display("Fail at time %0t: test %0d data fault %b, expected %b", $time, idx,
               got_fault, exp_flt);
      ok = 1'b0;
    end
    if (kind != "store" && want_lsu && got_done && !exp_flt && got_rdata !== exp_rdata) begin
      $display("Fail at time %0t: test %0d rdata %h, expected %h", $time, idx,
               got_rdata, exp_rdata);
      ok = 1'b0;
    end
    if (want_fetch && !got_fdone) begin
      $display("Test %0d: the fetch port gave no done pulse within %0d cycles", idx, DONE_WAIT);
      ok = 1'b0;
    end
    if (want_fetch && got_fdone && got_ffault !== exp_flt) begin
      $display("Fail at time %0t: test %0d fetch fault %b, expected %b", $time, idx,
               got_ffault, exp_flt);
      ok = 1'b0;
    end
    if (want_fetch && got_fdone && !exp_flt && got_instr !== exp_instr) begin
      $display("Fail at time %0t: test %0d instr %h, expected %h", $time, idx,
               got_instr, exp_instr);
      ok = 1'b0;
    end

    if (ok) begin
      pass_cnt++;
      $display("Test %0d %s addr %h ok", idx, kind, t_addr[idx]);
    end else begin
      fail_cnt++;
      $display("Test %0d %s addr %h wrong", idx, kind, t_addr[idx]);
    end
  endtask

  initial begin
    bit ok;
    int n_idle;
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_req       = 1'b0;
    i_op        = dmem_pkg::MEM_NONE;
    i_we        = 1'b0;
    i_addr      = '0;
    i_wdata     = '0;
    i_fetch_req = 1'b0;
    i_pc        = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    lfsr        = 32'h4f4f;

    load_tests(ok);
    if (!ok) fail_cnt++;
    cycle_limit = 20 * t_kind.size() + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    check_reset_state();

    for (int i = 0; i < t_kind.size(); i++) begin
      pick_idle(n_idle);
      repeat (n_idle) begin
        @(posedge i_clk);
        #1;
      end
      run_test(i);
    end

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* test/mem_subsystem_tests.txt */
# kind op addr data expected fault, all hex; op 0 B 1 BU 2 H 3 HU 4 W 5 WU 6 D 7 none
# store writes data; load and fetch expect the value; both expects instr in data, rdata in expected
# Width round trip
store 6 108 0 0 0
store 0 108 85 0 0
load  0 108 0 ffffffffffffff85 0
load  1 108 0 85 0
store 2 10a 9abc 0 0
load  2 10a 0 ffffffffffff9abc 0
load  3 10a 0 9abc 0
store 4 10c fedcba98 0 0
load  4 10c 0 fffffffffedcba98 0
load  5 10c 0 fedcba98 0
store 4 110 12345678 0 0
load  4 110 0 12345678 0
load  2 112 0 1234 0
load  6 108 0 fedcba989abc0085 0
# Lane merge over a full word
store 6 100 0123456789abcdef 0 0
load  6 100 0 0123456789abcdef 0
store 0 101 11 0 0
store 2 106 2233 0 0
store 0 103 44 0 0
load  6 100 0 2233456744ab11ef 0
load  3 102 0 44ab 0
load  1 101 0 11 0
# Misaligned and no-op accesses leave memory unchanged
store 4 102 deadbeef 0 1
store 2 101 ffff 0 1
store 6 104 ffffffffffffffff 0 1
load  4 106 0 0 1
load  3 105 0 0 1
store 7 100 ffffffffffffffff 0 0
load  6 100 0 2233456744ab11ef 0
load  6 2100 0 2233456744ab11ef 0
# Fetch alone and together with a load
store 6 200 00c58533fff00513 0 0
fetch 0 200 0 fff00513 0
fetch 0 204 0 00c58533 0
fetch 0 202 0 0 1
both  6 200 fff00513 00c58533fff00513 0
both  5 204 00c58533 c58533 0
both  0 100 44ab11ef ffffffffffffffef 0
both  1 104 22334567 67 0
